// ==== hw/ahb_csr_pkg.sv ====
// Constants shared by the AHB-Lite CSR slave and its testbench
// Bus widths, AHB encodings, register map and fixed register values
package ahb_csr_pkg;

  localparam int unsigned AHB_DATA_WIDTH = 32;
  localparam int unsigned AHB_ADDR_WIDTH = 32;
  localparam int unsigned CSR_ADDR_WIDTH = 6;  // 16 word slots

  // htrans
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  // hsize, only up to the bus width
  localparam logic [2:0] HSIZE_BYTE = 3'b000;
  localparam logic [2:0] HSIZE_HALF = 3'b001;
  localparam logic [2:0] HSIZE_WORD = 3'b010;

  // Register byte offsets
  localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_HW_VERSION  = 6'h00;
  localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_CONTROL     = 6'h04;
  localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_STATUS      = 6'h08;
  localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_INTR_STATUS = 6'h0C;
  localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_INTR_ENABLE = 6'h10;
  localparam logic [CSR_ADDR_WIDTH-1:0] ADDR_SCRATCH     = 6'h14;

  localparam logic [AHB_DATA_WIDTH-1:0] HW_VERSION_VALUE = 32'h0001_0100;  // v1.1.0
  localparam logic [AHB_DATA_WIDTH-1:0] CONTROL_MASK     = 32'h0000_00FF;

  localparam int unsigned INTR_WIDTH = 8;  // Interrupt sources

endpackage

// ==== hw/ahb_decode.sv ====
// AHB-Lite address phase decode
// Turns each accepted transfer into one CPU interface request in the data phase
module ahb_decode import ahb_csr_pkg::*; (
  input  logic                      hclk_i,
  input  logic                      rst_n_i,
  input  logic [AHB_ADDR_WIDTH-1:0] haddr_i,
  input  logic [2:0]                hsize_i,
  input  logic [1:0]                htrans_i,
  input  logic [AHB_DATA_WIDTH-1:0] hwdata_i,
  input  logic                      hwrite_i,
  input  logic                      hsel_i,
  input  logic                      hready_i,
  input  logic                      busy_i,
  output logic                      cpuif_req_o,
  output logic                      cpuif_req_is_wr_o,
  output logic [CSR_ADDR_WIDTH-1:0] cpuif_addr_o,
  output logic [AHB_DATA_WIDTH-1:0] cpuif_wr_data_o,
  output logic [AHB_DATA_WIDTH-1:0] cpuif_wr_biten_o
);

  logic                      trans_valid;
  logic                      accept;
  logic [3:0]                byte_en;
  logic                      req_q;
  logic                      is_wr_q;
  logic [CSR_ADDR_WIDTH-1:0] addr_q;
  logic [3:0]                byte_en_q;

  always_comb begin
    trans_valid = 1'b0;
    case (htrans_i)
      HTRANS_NONSEQ, HTRANS_SEQ: trans_valid = 1'b1;
      HTRANS_IDLE, HTRANS_BUSY:  trans_valid = 1'b0;  // Zero-wait OKAY
    endcase
  end

  // Byte lanes from size and low address bits
  always_comb begin
    case (hsize_i)
      HSIZE_BYTE: byte_en = 4'b0001 << haddr_i[1:0];
      HSIZE_HALF: byte_en = 4'b0011 << {haddr_i[1], 1'b0};
      HSIZE_WORD: byte_en = 4'b1111;
      default:    byte_en = 4'b1111;
    endcase
  end

  // req_q keeps the request a single-cycle pulse
  assign accept = hsel_i & hready_i & trans_valid & ~busy_i & ~req_q;

  always_ff @(posedge hclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q <= 1'b0;
    end else begin
      req_q <= accept;
    end
  end

  always_ff @(posedge hclk_i) begin
    if (accept) begin
      is_wr_q   <= hwrite_i;
      addr_q    <= {haddr_i[CSR_ADDR_WIDTH-1:2], 2'b00};  // Word aligned
      byte_en_q <= byte_en;
    end
  end

  assign cpuif_req_o       = req_q;
  assign cpuif_req_is_wr_o = is_wr_q;
  assign cpuif_addr_o      = addr_q;
  assign cpuif_wr_data_o   = hwdata_i;  // Live data phase value

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      cpuif_wr_biten_o[8*i +: 8] = {8{byte_en_q[i]}};
    end
  end

  // Response stage must have released the bus
  a_no_req_while_busy : assert property (@(posedge hclk_i) disable iff (!rst_n_i)
    cpuif_req_o |-> !busy_i);

endmodule

// ==== hw/csr_regfile.sv ====
// Six-register CSR block behind the CPU request/acknowledge interface
// Control output, sampled status input and a W1C interrupt block with enable mask
module csr_regfile import ahb_csr_pkg::*; (
  input  logic                      hclk_i,
  input  logic                      rst_n_i,
  input  logic                      cpuif_req_i,
  input  logic                      cpuif_req_is_wr_i,
  input  logic [CSR_ADDR_WIDTH-1:0] cpuif_addr_i,
  input  logic [AHB_DATA_WIDTH-1:0] cpuif_wr_data_i,
  input  logic [AHB_DATA_WIDTH-1:0] cpuif_wr_biten_i,
  input  logic [AHB_DATA_WIDTH-1:0] status_i,
  input  logic [INTR_WIDTH-1:0]     event_i,
  output logic                      cpuif_rd_ack_o,
  output logic                      cpuif_rd_err_o,
  output logic [AHB_DATA_WIDTH-1:0] cpuif_rd_data_o,
  output logic                      cpuif_wr_ack_o,
  output logic                      cpuif_wr_err_o,
  output logic [7:0]                ctrl_o,
  output logic                      irq_o
);

  logic [AHB_DATA_WIDTH-1:0] ctrl_q;
  logic [AHB_DATA_WIDTH-1:0] scratch_q;
  logic [AHB_DATA_WIDTH-1:0] status_q;
  logic [INTR_WIDTH-1:0]     intr_status_q;
  logic [INTR_WIDTH-1:0]     intr_en_q;
  logic                      rd_req;
  logic                      wr_req;
  logic                      rd_ok;
  logic                      wr_ok;
  logic                      wr_hit;
  logic [AHB_DATA_WIDTH-1:0] rd_mux;
  logic [AHB_DATA_WIDTH-1:0] wr_bits;
  logic [INTR_WIDTH-1:0]     intr_clr;

  assign rd_req  = cpuif_req_i & ~cpuif_req_is_wr_i;
  assign wr_req  = cpuif_req_i & cpuif_req_is_wr_i;
  assign wr_bits = cpuif_wr_data_i & cpuif_wr_biten_i;

  // Offset decode and read mux
  always_comb begin
    rd_ok  = 1'b1;
    wr_ok  = 1'b1;
    rd_mux = '0;
    case (cpuif_addr_i)
      ADDR_HW_VERSION: begin
        rd_mux = HW_VERSION_VALUE;
        wr_ok  = 1'b0;
      end
      ADDR_CONTROL:     rd_mux = ctrl_q;
      ADDR_STATUS: begin
        rd_mux = status_q;
        wr_ok  = 1'b0;  // Driven by hardware
      end
      ADDR_INTR_STATUS: rd_mux = AHB_DATA_WIDTH'(intr_status_q);
      ADDR_INTR_ENABLE: rd_mux = AHB_DATA_WIDTH'(intr_en_q);
      ADDR_SCRATCH:     rd_mux = scratch_q;
      default: begin
        rd_ok = 1'b0;
        wr_ok = 1'b0;
      end
    endcase
  end

  assign wr_hit   = wr_req & wr_ok;
  assign intr_clr = (wr_hit && cpuif_addr_i == ADDR_INTR_STATUS) ?
                    wr_bits[INTR_WIDTH-1:0] : '0;

  always_ff @(posedge hclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctrl_q         <= '0;
      scratch_q      <= '0;
      status_q       <= '0;
      intr_status_q  <= '0;
      intr_en_q      <= '0;
      irq_o          <= 1'b0;
      cpuif_rd_ack_o <= 1'b0;
      cpuif_rd_err_o <= 1'b0;
      cpuif_wr_ack_o <= 1'b0;
      cpuif_wr_err_o <= 1'b0;
    end else begin
      status_q       <= status_i;
      intr_status_q  <= (intr_status_q & ~intr_clr) | event_i;  // Set beats clear
      irq_o          <= |(intr_status_q & intr_en_q);
      cpuif_rd_ack_o <= rd_req;
      cpuif_rd_err_o <= rd_req & ~rd_ok;
      cpuif_wr_ack_o <= wr_req;
      cpuif_wr_err_o <= wr_req & ~wr_ok;
      if (wr_hit && cpuif_addr_i == ADDR_CONTROL) begin
        ctrl_q <= ((ctrl_q & ~cpuif_wr_biten_i) | wr_bits) & CONTROL_MASK;
      end
      if (wr_hit && cpuif_addr_i == ADDR_INTR_ENABLE) begin
        intr_en_q <= (intr_en_q & ~cpuif_wr_biten_i[INTR_WIDTH-1:0]) |
                     wr_bits[INTR_WIDTH-1:0];
      end
      if (wr_hit && cpuif_addr_i == ADDR_SCRATCH) begin
        scratch_q <= (scratch_q & ~cpuif_wr_biten_i) | wr_bits;
      end
    end
  end

  // Unmapped offsets already read as zero from the mux
  always_ff @(posedge hclk_i) begin
    if (rd_req) begin
      cpuif_rd_data_o <= rd_mux;
    end
  end

  assign ctrl_o = ctrl_q[7:0];

  a_ack_after_req : assert property (@(posedge hclk_i) disable iff (!rst_n_i)
    cpuif_req_i |=> (cpuif_rd_ack_o || cpuif_wr_ack_o));

  a_acks_exclusive : assert property (@(posedge hclk_i) disable iff (!rst_n_i)
    !(cpuif_rd_ack_o && cpuif_wr_ack_o));

endmodule

// ==== hw/ahb_result.sv ====
// AHB-Lite response stage
// Stretches the data phase until the CPU interface acknowledges, two-cycle ERROR
module ahb_result import ahb_csr_pkg::*; (
  input  logic                      hclk_i,
  input  logic                      rst_n_i,
  input  logic                      cpuif_req_i,
  input  logic                      cpuif_rd_ack_i,
  input  logic                      cpuif_rd_err_i,
  input  logic [AHB_DATA_WIDTH-1:0] cpuif_rd_data_i,
  input  logic                      cpuif_wr_ack_i,
  input  logic                      cpuif_wr_err_i,
  output logic [AHB_DATA_WIDTH-1:0] hrdata_o,
  output logic                      hreadyout_o,
  output logic                      hresp_o,
  output logic                      busy_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_ERR2
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   ack;
  logic   err;

  assign ack = cpuif_rd_ack_i | cpuif_wr_ack_i;
  assign err = (cpuif_rd_ack_i & cpuif_rd_err_i) | (cpuif_wr_ack_i & cpuif_wr_err_i);

  always_comb begin
    state_d     = state_q;
    hreadyout_o = 1'b1;
    hresp_o     = 1'b0;
    busy_o      = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (cpuif_req_i) begin
          state_d     = ST_WAIT;
          hreadyout_o = 1'b0;  // First data phase cycle
        end
      end
      ST_WAIT: begin
        if (err) begin
          state_d     = ST_ERR2;
          hreadyout_o = 1'b0;
          hresp_o     = 1'b1;
          busy_o      = 1'b1;
        end else if (ack) begin
          state_d = ST_IDLE;
        end else begin
          hreadyout_o = 1'b0;
          busy_o      = 1'b1;
        end
      end
      ST_ERR2: begin
        hresp_o = 1'b1;  // Second ERROR cycle, ready high
        state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge hclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign hrdata_o = cpuif_rd_ack_i ? cpuif_rd_data_i : '0;

  a_hresp_rise_not_ready : assert property (@(posedge hclk_i) disable iff (!rst_n_i)
    $rose(hresp_o) |-> !hreadyout_o);

endmodule

// ==== hw/ahb_csr_top.sv ====
// AHB-Lite slave with a small CSR block
// Decode, register file and response stage joined by the CPU interface
module ahb_csr_top import ahb_csr_pkg::*; (
  input  logic                      hclk_i,
  input  logic                      rst_n_i,
  input  logic [AHB_ADDR_WIDTH-1:0] haddr_i,
  input  logic [2:0]                hburst_i,  // Bursts run as single transfers
  input  logic [3:0]                hprot_i,
  input  logic [2:0]                hsize_i,
  input  logic [1:0]                htrans_i,
  input  logic [AHB_DATA_WIDTH-1:0] hwdata_i,
  input  logic                      hwrite_i,
  input  logic                      hsel_i,
  input  logic                      hready_i,
  output logic [AHB_DATA_WIDTH-1:0] hrdata_o,
  output logic                      hreadyout_o,
  output logic                      hresp_o,
  output logic [7:0]                ctrl_o,
  input  logic [AHB_DATA_WIDTH-1:0] status_i,
  input  logic [INTR_WIDTH-1:0]     event_i,
  output logic                      irq_o
);

  logic                      cpuif_req;
  logic                      cpuif_req_is_wr;
  logic [CSR_ADDR_WIDTH-1:0] cpuif_addr;
  logic [AHB_DATA_WIDTH-1:0] cpuif_wr_data;
  logic [AHB_DATA_WIDTH-1:0] cpuif_wr_biten;
  logic                      cpuif_rd_ack;
  logic                      cpuif_rd_err;
  logic [AHB_DATA_WIDTH-1:0] cpuif_rd_data;
  logic                      cpuif_wr_ack;
  logic                      cpuif_wr_err;
  logic                      busy;

  ahb_decode u_decode (
    .hclk_i            (hclk_i),
    .rst_n_i           (rst_n_i),
    .haddr_i           (haddr_i),
    .hsize_i           (hsize_i),
    .htrans_i          (htrans_i),
    .hwdata_i          (hwdata_i),
    .hwrite_i          (hwrite_i),
    .hsel_i            (hsel_i),
    .hready_i          (hready_i),
    .busy_i            (busy),
    .cpuif_req_o       (cpuif_req),
    .cpuif_req_is_wr_o (cpuif_req_is_wr),
    .cpuif_addr_o      (cpuif_addr),
    .cpuif_wr_data_o   (cpuif_wr_data),
    .cpuif_wr_biten_o  (cpuif_wr_biten)
  );

  csr_regfile u_regfile (
    .hclk_i            (hclk_i),
    .rst_n_i           (rst_n_i),
    .cpuif_req_i       (cpuif_req),
    .cpuif_req_is_wr_i (cpuif_req_is_wr),
    .cpuif_addr_i      (cpuif_addr),
    .cpuif_wr_data_i   (cpuif_wr_data),
    .cpuif_wr_biten_i  (cpuif_wr_biten),
    .status_i          (status_i),
    .event_i           (event_i),
    .cpuif_rd_ack_o    (cpuif_rd_ack),
    .cpuif_rd_err_o    (cpuif_rd_err),
    .cpuif_rd_data_o   (cpuif_rd_data),
    .cpuif_wr_ack_o    (cpuif_wr_ack),
    .cpuif_wr_err_o    (cpuif_wr_err),
    .ctrl_o            (ctrl_o),
    .irq_o             (irq_o)
  );

  ahb_result u_result (
    .hclk_i          (hclk_i),
    .rst_n_i         (rst_n_i),
    .cpuif_req_i     (cpuif_req),
    .cpuif_rd_ack_i  (cpuif_rd_ack),
    .cpuif_rd_err_i  (cpuif_rd_err),
    .cpuif_rd_data_i (cpuif_rd_data),
    .cpuif_wr_ack_i  (cpuif_wr_ack),
    .cpuif_wr_err_i  (cpuif_wr_err),
    .hrdata_o        (hrdata_o),
    .hreadyout_o     (hreadyout_o),
    .hresp_o         (hresp_o),
    .busy_o          (busy)
  );

endmodule

// ==== bench/tb_ahb_csr.sv ====
// Testbench for the AHB-Lite CSR slave
// Replays bench/ahb_csr_input.txt one test per line and checks bus and sideband responses
module tb_ahb_csr import ahb_csr_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  logic                      hclk;
  logic                      rst_n;
  logic [AHB_ADDR_WIDTH-1:0] haddr;
  logic [2:0]                hburst;
  logic [3:0]                hprot;
  logic [2:0]                hsize;
  logic [1:0]                htrans;
  logic [AHB_DATA_WIDTH-1:0] hwdata;
  logic                      hwrite;
  logic                      hsel;
  logic                      hready;
  logic [AHB_DATA_WIDTH-1:0] hrdata;
  logic                      hreadyout;
  logic                      hresp;
  logic [7:0]                ctrl;
  logic [AHB_DATA_WIDTH-1:0] status;
  logic [INTR_WIDTH-1:0]     evt;
  logic                      irq;

  // One entry per test line
  string                     name_q[$];
  string                     op_q[$];
  string                     resp_q[$];
  logic [AHB_ADDR_WIDTH-1:0] addr_q[$];
  logic [2:0]                size_q[$];
  logic [AHB_DATA_WIDTH-1:0] wdata_q[$];
  logic [AHB_DATA_WIDTH-1:0] status_q[$];
  logic [INTR_WIDTH-1:0]     event_q[$];
  logic [AHB_DATA_WIDTH-1:0] rdata_q[$];
  logic                      irq_q[$];
  logic [7:0]                ctrl_q[$];

  int errors = 0;
  int passed = 0;
  int failed = 0;
  int cycles = 0;
  int limit  = 0;

  assign hready = hreadyout;  // Single-slave system

  ahb_csr_top dut (
    .hclk_i      (hclk),
    .rst_n_i     (rst_n),
    .haddr_i     (haddr),
    .hburst_i    (hburst),
    .hprot_i     (hprot),
    .hsize_i     (hsize),
    .htrans_i    (htrans),
    .hwdata_i    (hwdata),
    .hwrite_i    (hwrite),
    .hsel_i      (hsel),
    .hready_i    (hready),
    .hrdata_o    (hrdata),
    .hreadyout_o (hreadyout),
    .hresp_o     (hresp),
    .ctrl_o      (ctrl),
    .status_i    (status),
    .event_i     (evt),
    .irq_o       (irq)
  );

  initial begin
    hclk = 1'b0;
    forever #5 hclk = ~hclk;
  end

  always @(posedge hclk) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // Address phase on this falling edge, data phase on the next
  task automatic run_transfer(input int idx);
    int   waits;
    logic first_err;
    logic is_wr;
    logic exp_err;
    is_wr     = (op_q[idx] == "W");
    exp_err   = (resp_q[idx] == "ERROR");
    waits     = 0;
    first_err = 1'b0;
    haddr  = addr_q[idx];
    hsize  = size_q[idx];
    hwrite = is_wr;
    htrans = HTRANS_NONSEQ;
    hsel   = 1'b1;
    @(negedge hclk);
    htrans = HTRANS_IDLE;
    hsel   = 1'b0;
    hwdata = is_wr ? wdata_q[idx] : '0;
    while (!hreadyout) begin
      first_err = first_err | hresp;
      waits++;
      @(negedge hclk);
    end
    assert (hresp == exp_err) else begin
      $display("Error %s: hresp expected %0d, actual %0d", name_q[idx], exp_err, hresp);
      errors++;
    end
    assert (waits == (exp_err ? 2 : 1)) else begin
      $display("Error %s: wait cycles expected %0d, actual %0d", name_q[idx],
               exp_err ? 2 : 1, waits);
      errors++;
    end
    if (exp_err) begin
      assert (first_err) else begin
        $display("%s: ERROR response did not start while hreadyout was low", name_q[idx]);
        errors++;
      end
    end
    if (!is_wr && !exp_err) begin
      assert (hrdata == rdata_q[idx]) else begin
        $display("Error %s: hrdata expected %h, actual %h", name_q[idx], rdata_q[idx], hrdata);
        errors++;
      end
    end
  endtask

  task automatic pulse_event(input int idx);
    evt = event_q[idx];
    @(negedge hclk);
    evt = '0;
    @(negedge hclk);  // irq is one register behind INTR_STATUS
  endtask

  task automatic check_sideband(input int idx);
    assert (irq == irq_q[idx]) else begin
      $display("Error %s: irq_o expected %0d, actual %0d", name_q[idx], irq_q[idx], irq);
      errors++;
    end
    assert (ctrl == ctrl_q[idx]) else begin
      $display("Error %s: ctrl_o expected %h, actual %h", name_q[idx], ctrl_q[idx], ctrl);
      errors++;
    end
  endtask

  initial begin
    int                        fd;
    int                        n;
    int                        gap;
    int                        errs_before;
    string                     tok;
    string                     op;
    string                     resp;
    logic [8*128-1:0]          skip_line;
    logic [AHB_ADDR_WIDTH-1:0] addr;
    logic [2:0]                size;
    logic [AHB_DATA_WIDTH-1:0] wdata;
    logic [AHB_DATA_WIDTH-1:0] stat;
    logic [INTR_WIDTH-1:0]     ev;
    logic [AHB_DATA_WIDTH-1:0] rdata;
    logic                      exp_irq;
    logic [7:0]                exp_ctrl;
    rst_n  = 1'b0;
    haddr  = '0;
    hburst = '0;
    hprot  = '0;
    hsize  = HSIZE_WORD;
    htrans = HTRANS_IDLE;
    hwdata = '0;
    hwrite = 1'b0;
    hsel   = 1'b0;
    status = '0;
    evt    = '0;
    void'($urandom(32'hed25db1f));

    fd = $fopen("bench/ahb_csr_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open bench/ahb_csr_input.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        n = $fscanf(fd, "%s", tok);
        if (n == 1) begin
          if (tok.getc(0) == "#") begin
            n = $fgets(skip_line, fd);
          end else begin
            n = $fscanf(fd, "%s %h %h %h %h %h %h %s %h %h", op, addr, size, wdata, stat,
                        ev, rdata, resp, exp_irq, exp_ctrl);
            if (n == 10) begin
              name_q.push_back(tok);
              op_q.push_back(op);
              addr_q.push_back(addr);
              size_q.push_back(size);
              wdata_q.push_back(wdata);
              status_q.push_back(stat);
              event_q.push_back(ev);
              rdata_q.push_back(rdata);
              resp_q.push_back(resp);
              irq_q.push_back(exp_irq);
              ctrl_q.push_back(exp_ctrl);
            end else begin
              $display("Malformed input line for test %s", tok);
              errors++;
            end
          end
        end
      end
      $fclose(fd);
    end
    limit = 8 * name_q.size() + 100;

    repeat (5) @(posedge hclk);
    @(negedge hclk);
    rst_n = 1'b1;
    @(negedge hclk);

    for (int i = 0; i < name_q.size(); i++) begin
      status = status_q[i];
      gap    = $urandom_range(3, 0);
      repeat (gap) @(negedge hclk);
      errs_before = errors;
      if (op_q[i] == "E") begin
        pulse_event(i);
      end else if (op_q[i] == "W" || op_q[i] == "R") begin
        run_transfer(i);
      end else begin
        $display("Unknown operation %s in test %s", op_q[i], name_q[i]);
        errors++;
      end
      check_sideband(i);
      if (errors == errs_before) begin
        passed++;
        $display("test %s ok", name_q[i]);
      end else begin
        failed++;
        $display("test %s mismatch", name_q[i]);
      end
    end

    $display("%0d tests, %0d passed, %0d failed, %0d errors", name_q.size(), passed, failed,
             errors);
    if (errors == 0 && failed == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== bench/ahb_csr_input.txt ====
# name op addr size wdata status event exp_rdata exp_resp exp_irq exp_ctrl, numbers in hex
# op W write, R read, E one-cycle event_i pulse; size 0 byte, 1 half, 2 word
rst_version   R 00 2 00000000 00000000 00 00010100 OKAY  0 00
rst_control   R 04 2 00000000 00000000 00 00000000 OKAY  0 00
rst_status    R 08 2 00000000 00000000 00 00000000 OKAY  0 00
rst_intr_sts  R 0c 2 00000000 00000000 00 00000000 OKAY  0 00
rst_intr_en   R 10 2 00000000 00000000 00 00000000 OKAY  0 00
rst_scratch   R 14 2 00000000 00000000 00 00000000 OKAY  0 00
scr_word_wr   W 14 2 deadbeef 00000000 00 00000000 OKAY  0 00
scr_word_rd   R 14 2 00000000 00000000 00 deadbeef OKAY  0 00
ctl_word_wr   W 04 2 a5a5a5a5 00000000 00 00000000 OKAY  0 a5
ctl_word_rd   R 04 2 00000000 00000000 00 000000a5 OKAY  0 a5
scr_byte2_wr  W 16 0 77117777 00000000 00 00000000 OKAY  0 a5
scr_byte2_rd  R 14 2 00000000 00000000 00 de11beef OKAY  0 a5
scr_half0_wr  W 14 1 99992222 00000000 00 00000000 OKAY  0 a5
scr_half0_rd  R 14 2 00000000 00000000 00 de112222 OKAY  0 a5
scr_half2_wr  W 16 1 33334444 00000000 00 00000000 OKAY  0 a5
scr_byte0_wr  W 14 0 555555aa 00000000 00 00000000 OKAY  0 a5
scr_byte3_wr  W 17 0 c0121212 00000000 00 00000000 OKAY  0 a5
scr_mix_rd    R 14 2 00000000 00000000 00 c03322aa OKAY  0 a5
status_rd     R 08 2 00000000 12345678 00 12345678 OKAY  0 a5
intr_en_wr    W 10 2 00000005 00000000 00 00000000 OKAY  0 a5
intr_en_rd    R 10 2 00000000 00000000 00 00000005 OKAY  0 a5
event_pulse   E 00 2 00000000 00000000 06 00000000 OKAY  1 a5
intr_sts_rd   R 0c 2 00000000 00000000 00 00000006 OKAY  1 a5
intr_clr_wr   W 0c 2 00000004 00000000 00 00000000 OKAY  1 a5
intr_clr_rd   R 0c 2 00000000 00000000 00 00000002 OKAY  0 a5
unmap_rd      R 20 2 00000000 00000000 00 00000000 ERROR 0 a5
unmap_wr      W 3c 2 ffffffff 00000000 00 00000000 ERROR 0 a5
ver_wr        W 00 2 ffffffff 00000000 00 00000000 ERROR 0 a5
ver_rd        R 00 2 00000000 00000000 00 00010100 OKAY  0 a5
status_wr     W 08 2 ffffffff 12345678 00 00000000 ERROR 0 a5
status_rd2    R 08 2 00000000 12345678 00 12345678 OKAY  0 a5
scr_final_rd  R 14 2 00000000 00000000 00 c03322aa OKAY  0 a5
ctl_final_rd  R 04 2 00000000 00000000 00 000000a5 OKAY  0 a5

// ==== sources.f ====
hw/ahb_csr_pkg.sv
hw/ahb_decode.sv
hw/csr_regfile.sv
hw/ahb_result.sv
hw/ahb_csr_top.sv
bench/tb_ahb_csr.sv

// ==== Makefile ====
TOP = tb_ahb_csr
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f sources.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
